// ==== hw/icache_pkg.sv ====
`default_nettype none

package icache_pkg;

	// Fetch side byte address
	localparam int ADDR_W = 32;

	// One instruction word
	localparam int WORD_W = 32;

	// Memory bus beat, two words wide
	localparam int BEAT_W = 64;

	// A 32-byte line arrives in four beats
	localparam int BEATS = 4;

	// Byte offset inside a line
	localparam int OFFSET_W = 5;

	typedef logic [ADDR_W-1:0] addr_t;
	typedef logic [WORD_W-1:0] word_t;
	typedef logic [BEAT_W-1:0] beat_t;

	// Beat number inside a line, also address bits [4:3]
	typedef logic [1:0] beat_idx_t;

	// Controller states
	typedef enum logic [2:0] {
		IDLE,
		LOOKUP,
		REFILL_ADDR,
		REFILL_DATA,
		RESPOND,
		FLUSH
	} ctrl_state_t;

endpackage

`default_nettype wire

// ==== hw/icache_way_if.sv ====
`timescale 1ns/10ps
`default_nettype none

interface icache_way_if #(
	parameter int LINES = 64
);

	// Set index and tag widths follow the number of sets
	localparam int IDX_W = $clog2(LINES);
	localparam int TAG_W = icache_pkg::ADDR_W - icache_pkg::OFFSET_W - IDX_W;

	// Lookup side
	logic lookup_en;
	logic [IDX_W-1:0] index;
	logic [TAG_W-1:0] tag;
	icache_pkg::beat_idx_t beat_sel;

	// Refill side, one beat per strobe
	logic fill_en;
	icache_pkg::beat_idx_t fill_beat;
	icache_pkg::beat_t fill_data;
	logic alloc;
	logic inval_all;

	// Results back from the way
	logic hit;
	icache_pkg::beat_t rd_beat;
	logic line_valid;

	modport ctrl (
		output lookup_en, index, tag, beat_sel,
		output fill_en, fill_beat, fill_data, alloc, inval_all,
		input hit, rd_beat, line_valid
	);

	modport way (
		input lookup_en, index, tag, beat_sel,
		input fill_en, fill_beat, fill_data, alloc, inval_all,
		output hit, rd_beat, line_valid
	);

endinterface

`default_nettype wire

// ==== hw/icache_way.sv ====
`timescale 1ns/10ps
`default_nettype none

module icache_way #(
	parameter int LINES = 64
) (
	input wire logic CLK,
	input wire logic rst,
	icache_way_if.way port
);

	localparam int IDX_W = $clog2(LINES);
	localparam int TAG_W = icache_pkg::ADDR_W - icache_pkg::OFFSET_W - IDX_W;
	localparam int BEAT_IDX_W = $bits(icache_pkg::beat_idx_t);

	// Data array is addressed by {index, beat}
	localparam int DATA_AW = IDX_W + BEAT_IDX_W;

	// One tag per set
	logic [TAG_W-1:0] tag_mem [LINES];

	// Valid bits sit in flops so a flush clears them in one cycle
	logic [LINES-1:0] valid;

	// LINES x BEATS beats of line data
	icache_pkg::beat_t data_mem [LINES*icache_pkg::BEATS];

	logic [DATA_AW-1:0] rd_addr;
	logic [DATA_AW-1:0] wr_addr;
	logic tag_match;
	logic hit_q;
	icache_pkg::beat_t rd_q;

	assign rd_addr = {port.index, port.beat_sel};
	assign wr_addr = {port.index, port.fill_beat};

	// Compare against the stored tag of the indexed set
	assign tag_match = valid[port.index] && (tag_mem[port.index] == port.tag);

	// Victim choice needs the valid bit right away
	assign port.line_valid = valid[port.index];

	assign port.hit = hit_q;
	assign port.rd_beat = rd_q;

	// Valid bits
	always_ff @(posedge CLK) begin
		if (rst || port.inval_all) begin
			valid <= '0;
		end else if (port.alloc) begin
			valid[port.index] <= 1'b1;
		end
	end

	// Tag written once per refill, when the victim is picked
	always_ff @(posedge CLK) begin
		if (port.alloc) begin
			tag_mem[port.index] <= port.tag;
		end
	end

	// Beat write from the refill burst
	always_ff @(posedge CLK) begin
		if (port.fill_en) begin
			data_mem[wr_addr] <= port.fill_data;
		end
	end

	// Registered hit flag
	always_ff @(posedge CLK) begin
		if (rst) begin
			hit_q <= 1'b0;
		end else if (port.lookup_en) begin
			hit_q <= tag_match;
		end
	end

	// Registered read beat
	// The last refill beat lands on the same edge as the re-lookup, so forward it
	always_ff @(posedge CLK) begin
		if (port.lookup_en) begin
			if (port.fill_en && (wr_addr == rd_addr)) begin
				rd_q <= port.fill_data;
			end else begin
				rd_q <= data_mem[rd_addr];
			end
		end
	end

endmodule

`default_nettype wire

// ==== hw/victim_select.sv ====
`timescale 1ns/10ps
`default_nettype none

module victim_select (
	input wire logic CLK,
	input wire logic rst,
	input wire logic [1:0] line_valid,
	output logic [1:0] victim
);

	// Nonzero start value, the all-zero state would lock up
	localparam logic [7:0] SEED = 8'hA5;

	logic [7:0] lfsr;
	logic feedback;

	// x^8 + x^6 + x^5 + x^4 + 1, maximal length
	assign feedback = lfsr[7] ^ lfsr[5] ^ lfsr[4] ^ lfsr[3];

	// Free-running, steps every cycle
	always_ff @(posedge CLK) begin
		if (rst) begin
			lfsr <= SEED;
		end else begin
			lfsr <= {lfsr[6:0], feedback};
		end
	end

	// Lowest free way first
	// When both ways are taken, the LFSR low bit picks one
	always_comb begin
		if (!line_valid[0]) begin
			victim = 2'b01;
		end else if (!line_valid[1]) begin
			victim = 2'b10;
		end else if (lfsr[0]) begin
			victim = 2'b10;
		end else begin
			victim = 2'b01;
		end
	end

endmodule

`default_nettype wire

// ==== hw/icache_ctrl.sv ====
`timescale 1ns/10ps
`default_nettype none

module icache_ctrl #(
	parameter int LINES = 64
) (
	input wire logic CLK,
	input wire logic rst,

	// Fetch request
	input wire logic req_valid,
	output logic req_ready,
	input wire icache_pkg::addr_t req_addr,

	// Fetch response
	output logic rsp_valid,
	input wire logic rsp_ready,
	output icache_pkg::word_t rsp_data,

	input wire logic flush,

	// Refill read channel
	output icache_pkg::addr_t mem_araddr,
	output logic mem_arvalid,
	input wire logic mem_arready,
	input wire icache_pkg::beat_t mem_rdata,
	input wire logic mem_rlast,
	input wire logic mem_rvalid,
	output logic mem_rready,

	icache_way_if.ctrl way0,
	icache_way_if.ctrl way1,
	input wire logic [1:0] victim
);

	localparam int IDX_W = $clog2(LINES);
	localparam int TAG_W = icache_pkg::ADDR_W - icache_pkg::OFFSET_W - IDX_W;
	localparam int WORD_W = icache_pkg::WORD_W;

	icache_pkg::ctrl_state_t state;
	icache_pkg::ctrl_state_t state_nxt;

	// Captured fetch address and the address the ways look at
	icache_pkg::addr_t addr_q;
	icache_pkg::addr_t look_addr;

	logic [1:0] victim_q;
	icache_pkg::beat_idx_t beat_cnt;
	icache_pkg::beat_t hit_beat;

	logic accept;
	logic rd_fire;
	logic refill_done;
	logic lookup_en;
	logic hit_any;
	logic miss;

	// Handshakes
	assign req_ready = (state == icache_pkg::IDLE) && !flush;
	assign accept = req_valid && req_ready;
	assign rsp_valid = (state == icache_pkg::RESPOND);

	assign mem_arvalid = (state == icache_pkg::REFILL_ADDR);
	assign mem_rready = (state == icache_pkg::REFILL_DATA);
	assign mem_araddr = {addr_q[icache_pkg::ADDR_W-1:icache_pkg::OFFSET_W],
		{icache_pkg::OFFSET_W{1'b0}}};

	assign rd_fire = mem_rvalid && mem_rready;
	assign refill_done = rd_fire && mem_rlast;

	// Ways read on acceptance and again on the last refill beat
	assign lookup_en = accept || refill_done;

	// In IDLE the request goes straight to the arrays
	assign look_addr = (state == icache_pkg::IDLE) ? req_addr : addr_q;

	// Hit combine, at most one way hits
	assign hit_any = way0.hit || way1.hit;
	assign hit_beat = way0.hit ? way0.rd_beat : way1.rd_beat;
	assign miss = (state == icache_pkg::LOOKUP) && !hit_any;

	// Next state
	always_comb begin
		state_nxt = state;
		case (state)
			icache_pkg::IDLE: begin
				// Flush has priority over a new fetch
				if (flush) begin
					state_nxt = icache_pkg::FLUSH;
				end else if (req_valid) begin
					state_nxt = icache_pkg::LOOKUP;
				end
			end
			icache_pkg::LOOKUP: begin
				if (hit_any) begin
					state_nxt = icache_pkg::RESPOND;
				end else begin
					state_nxt = icache_pkg::REFILL_ADDR;
				end
			end
			icache_pkg::REFILL_ADDR: begin
				if (mem_arready) begin
					state_nxt = icache_pkg::REFILL_DATA;
				end
			end
			icache_pkg::REFILL_DATA: begin
				// Back to LOOKUP, which now hits
				if (refill_done) begin
					state_nxt = icache_pkg::LOOKUP;
				end
			end
			icache_pkg::RESPOND: begin
				if (rsp_ready) begin
					state_nxt = icache_pkg::IDLE;
				end
			end
			icache_pkg::FLUSH: begin
				state_nxt = icache_pkg::IDLE;
			end
			default: begin
				state_nxt = icache_pkg::IDLE;
			end
		endcase
	end

	always_ff @(posedge CLK) begin
		if (rst) begin
			state <= icache_pkg::IDLE;
		end else begin
			state <= state_nxt;
		end
	end

	always_ff @(posedge CLK) begin
		if (accept) begin
			addr_q <= req_addr;
		end
	end

	// Victim held for the whole burst
	always_ff @(posedge CLK) begin
		if (rst) begin
			victim_q <= 2'b00;
		end else if (miss) begin
			victim_q <= victim;
		end
	end

	// Beat counter, cleared while the address phase is pending
	always_ff @(posedge CLK) begin
		if (rst) begin
			beat_cnt <= '0;
		end else if (state == icache_pkg::REFILL_ADDR) begin
			beat_cnt <= '0;
		end else if (rd_fire) begin
			beat_cnt <= beat_cnt + 1'b1;
		end
	end

	// Word pick by address bit 2, lower address in the low half
	always_ff @(posedge CLK) begin
		if ((state == icache_pkg::LOOKUP) && hit_any) begin
			if (addr_q[2]) begin
				rsp_data <= hit_beat[WORD_W +: WORD_W];
			end else begin
				rsp_data <= hit_beat[0 +: WORD_W];
			end
		end
	end

	// Way 0 strobes
	assign way0.lookup_en = lookup_en;
	assign way0.index = look_addr[icache_pkg::OFFSET_W +: IDX_W];
	assign way0.tag = look_addr[icache_pkg::ADDR_W-1 -: TAG_W];
	assign way0.beat_sel = look_addr[icache_pkg::OFFSET_W-1 -: 2];
	assign way0.fill_en = rd_fire && victim_q[0];
	assign way0.fill_beat = beat_cnt;
	assign way0.fill_data = mem_rdata;
	assign way0.alloc = miss && victim[0];
	assign way0.inval_all = (state == icache_pkg::FLUSH);

	// Way 1 strobes
	assign way1.lookup_en = lookup_en;
	assign way1.index = look_addr[icache_pkg::OFFSET_W +: IDX_W];
	assign way1.tag = look_addr[icache_pkg::ADDR_W-1 -: TAG_W];
	assign way1.beat_sel = look_addr[icache_pkg::OFFSET_W-1 -: 2];
	assign way1.fill_en = rd_fire && victim_q[1];
	assign way1.fill_beat = beat_cnt;
	assign way1.fill_data = mem_rdata;
	assign way1.alloc = miss && victim[1];
	assign way1.inval_all = (state == icache_pkg::FLUSH);

endmodule

`default_nettype wire

// ==== hw/icache_top.sv ====
`timescale 1ns/10ps
`default_nettype none

module icache_top #(
	parameter int LINES = 64
) (
	input wire logic CLK,
	input wire logic rst,

	// Fetch side
	input wire logic req_valid,
	output logic req_ready,
	input wire icache_pkg::addr_t req_addr,
	output logic rsp_valid,
	input wire logic rsp_ready,
	output icache_pkg::word_t rsp_data,

	// Invalidate all lines
	input wire logic flush,

	// Memory side, read only
	output icache_pkg::addr_t mem_araddr,
	output logic mem_arvalid,
	input wire logic mem_arready,
	input wire icache_pkg::beat_t mem_rdata,
	input wire logic mem_rlast,
	input wire logic mem_rvalid,
	output logic mem_rready
);

	logic [1:0] victim;

	// One bus per way
	icache_way_if #(.LINES(LINES)) way0_bus ();
	icache_way_if #(.LINES(LINES)) way1_bus ();

	icache_ctrl #(
		.LINES(LINES)
	) ctrl (
		.CLK(CLK),
		.rst(rst),
		.req_valid(req_valid),
		.req_ready(req_ready),
		.req_addr(req_addr),
		.rsp_valid(rsp_valid),
		.rsp_ready(rsp_ready),
		.rsp_data(rsp_data),
		.flush(flush),
		.mem_araddr(mem_araddr),
		.mem_arvalid(mem_arvalid),
		.mem_arready(mem_arready),
		.mem_rdata(mem_rdata),
		.mem_rlast(mem_rlast),
		.mem_rvalid(mem_rvalid),
		.mem_rready(mem_rready),
		.way0(way0_bus.ctrl),
		.way1(way1_bus.ctrl),
		.victim(victim)
	);

	icache_way #(.LINES(LINES)) way0 (
		.CLK(CLK),
		.rst(rst),
		.port(way0_bus.way)
	);

	icache_way #(.LINES(LINES)) way1 (
		.CLK(CLK),
		.rst(rst),
		.port(way1_bus.way)
	);

	// Replacement looks at both valid bits of the current set
	victim_select victim_sel (
		.CLK(CLK),
		.rst(rst),
		.line_valid({way1_bus.line_valid, way0_bus.line_valid}),
		.victim(victim)
	);

endmodule

`default_nettype wire

// ==== tests/icache_tb.sv ====
`timescale 1ns/10ps
`default_nettype none

module icache_tb;

	localparam int SEED = 49855;
	localparam int N_FETCH = 400;
	localparam int TIMEOUT = 200;
	localparam icache_pkg::word_t MAGIC = 32'h5A5A0000;

	logic CLK;
	logic rst;
	logic req_valid;
	logic req_ready;
	icache_pkg::addr_t req_addr;
	logic rsp_valid;
	logic rsp_ready;
	icache_pkg::word_t rsp_data;
	logic flush;
	icache_pkg::addr_t mem_araddr;
	logic mem_arvalid;
	logic mem_arready;
	icache_pkg::beat_t mem_rdata;
	logic mem_rlast;
	logic mem_rvalid;
	logic mem_rready;

	int err_value;
	int err_other;
	bit timed_out;

	// Memory responder state
	int ar_count;
	int beats_taken;
	bit burst_active;
	int beat_n;
	icache_pkg::addr_t burst_line;
	icache_pkg::addr_t beat_addr;
	icache_pkg::addr_t cur_line;

	// Lines surely resident, and lines fetched since the last flush
	bit resident [icache_pkg::addr_t];
	bit seen [icache_pkg::addr_t];

	icache_top dut (
		.CLK(CLK),
		.rst(rst),
		.req_valid(req_valid),
		.req_ready(req_ready),
		.req_addr(req_addr),
		.rsp_valid(rsp_valid),
		.rsp_ready(rsp_ready),
		.rsp_data(rsp_data),
		.flush(flush),
		.mem_araddr(mem_araddr),
		.mem_arvalid(mem_arvalid),
		.mem_arready(mem_arready),
		.mem_rdata(mem_rdata),
		.mem_rlast(mem_rlast),
		.mem_rvalid(mem_rvalid),
		.mem_rready(mem_rready)
	);

	always #5 CLK = ~CLK;

	task automatic check_word(input string name, input icache_pkg::word_t got,
		input icache_pkg::word_t exp);
		if (got !== exp) begin
			err_value++;
			$display("[ERROR] %s: got %h, expected %h", name, got, exp);
		end
	endtask

	task automatic check_addr(input string name, input icache_pkg::addr_t got,
		input icache_pkg::addr_t exp);
		if (got !== exp) begin
			err_value++;
			$display("[ERROR] %s: got %h, expected %h", name, got, exp);
		end
	endtask

	task automatic check_flag(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			err_value++;
			$display("[ERROR] %s: got %h, expected %h", name, got, exp);
		end
	endtask

	task automatic check_count(input string name, input int got, input int exp);
		if (got != exp) begin
			err_value++;
			$display("[ERROR] %s: got %0h, expected %0h", name, got, exp);
		end
	endtask

	task automatic report_timeout(input string what);
		err_other++;
		timed_out = 1'b1;
		$display("Timeout: %s", what);
	endtask

	// Memory responder stepping on every falling edge
	// A beat for byte address A holds word(A) low and word(A+4) high
	always @(negedge CLK) begin
		if (rst) begin
			mem_arready = 1'b0;
			mem_rvalid = 1'b0;
			mem_rlast = 1'b0;
			burst_active = 1'b0;
		end else begin
			mem_rvalid = 1'b0;
			mem_rlast = 1'b0;
			if (burst_active) begin
				if (!mem_rready) begin
					err_other++;
					$display("mem_rready is low in the middle of a refill burst");
				end else if ($urandom_range(0, 3) != 0) begin
					beat_addr = burst_line + beat_n * 8;
					mem_rdata = {(beat_addr + 32'd4) ^ MAGIC, beat_addr ^ MAGIC};
					mem_rvalid = 1'b1;
					mem_rlast = (beat_n == icache_pkg::BEATS - 1);
					beat_n++;
					beats_taken++;
					if (beat_n == icache_pkg::BEATS) begin
						burst_active = 1'b0;
					end
				end
			end
			mem_arready = 1'b0;
			if (mem_arvalid) begin
				if (burst_active) begin
					err_other++;
					$display("a refill address was issued while a burst was running");
				end
				// Random address phase delay
				if ($urandom_range(0, 2) == 0) begin
					mem_arready = 1'b1;
					check_addr("mem_araddr", mem_araddr, cur_line);
					burst_line = mem_araddr;
					burst_active = 1'b1;
					beat_n = 0;
					ar_count++;
				end
			end
		end
	end

	// A refill may evict any other line of the same set
	task automatic evict_set(input icache_pkg::addr_t line);
		icache_pkg::addr_t gone [$];
		foreach (resident[k]) begin
			if ((k[10:5] == line[10:5]) && (k != line)) begin
				gone.push_back(k);
			end
		end
		foreach (gone[i]) begin
			resident.delete(gone[i]);
		end
	endtask

	task automatic flush_cache();
		flush = 1'b1;
		@(negedge CLK);
		check_flag("req_ready", req_ready, 1'b0);
		flush = 1'b0;
		@(negedge CLK);
		// FLUSH is a single cycle
		check_flag("req_ready", req_ready, 1'b1);
		resident.delete();
		seen.delete();
	endtask

	task automatic fetch_word(input icache_pkg::addr_t addr);
		icache_pkg::addr_t line;
		icache_pkg::word_t held;
		bit known;
		bit fresh;
		bit stalled;
		int ar0;
		int beats0;
		int cycles;
		int refills;
		int t;
		line = {addr[31:5], 5'b0};
		known = resident.exists(line);
		fresh = !seen.exists(line);
		cur_line = line;
		ar0 = ar_count;
		beats0 = beats_taken;
		req_addr = addr;
		req_valid = 1'b1;
		t = 0;
		while (!req_ready) begin
			if (t > TIMEOUT) begin
				report_timeout("the fetch request was never accepted");
				return;
			end
			@(negedge CLK);
			t++;
		end
		// Taken on the rising edge just passed
		@(negedge CLK);
		req_valid = 1'b0;
		cycles = 1;
		while (!rsp_valid) begin
			if (cycles > TIMEOUT) begin
				report_timeout("no response arrived for a fetch");
				return;
			end
			@(negedge CLK);
			cycles++;
		end
		check_word("rsp_data", rsp_data, addr ^ MAGIC);
		held = rsp_data;
		refills = ar_count - ar0;
		if (known) begin
			check_count("refill requests", refills, 0);
			check_count("hit latency", cycles, 2);
		end else if (fresh || refills > 1) begin
			check_count("refill requests", refills, 1);
		end
		check_count("beats taken", beats_taken - beats0, icache_pkg::BEATS * refills);
		// Response with random back-pressure
		stalled = 1'b1;
		t = 0;
		while (stalled) begin
			if (t > TIMEOUT) begin
				report_timeout("the response handshake never completed");
				return;
			end
			rsp_ready = ($urandom_range(0, 2) != 0);
			stalled = !rsp_ready;
			@(negedge CLK);
			t++;
			if (stalled) begin
				check_flag("rsp_valid", rsp_valid, 1'b1);
				check_word("rsp_data", rsp_data, held);
				check_flag("req_ready", req_ready, 1'b0);
			end
		end
		rsp_ready = 1'b0;
		check_flag("rsp_valid", rsp_valid, 1'b0);
		if (refills > 0) begin
			evict_set(line);
		end
		resident[line] = 1'b1;
		seen[line] = 1'b1;
	endtask

	initial begin
		icache_pkg::addr_t line;
		icache_pkg::addr_t prev_line;
		bit have_prev;
		void'($urandom(SEED));
		CLK = 1'b0;
		rst = 1'b1;
		req_valid = 1'b0;
		req_addr = '0;
		rsp_ready = 1'b0;
		flush = 1'b0;
		mem_arready = 1'b0;
		mem_rdata = '0;
		mem_rlast = 1'b0;
		mem_rvalid = 1'b0;
		err_value = 0;
		err_other = 0;
		timed_out = 1'b0;
		ar_count = 0;
		beats_taken = 0;
		burst_active = 1'b0;
		beat_n = 0;
		cur_line = '0;
		have_prev = 1'b0;
		repeat (4) @(posedge CLK);
		@(negedge CLK);
		rst = 1'b0;
		// Idle outputs straight out of reset
		check_flag("req_ready", req_ready, 1'b1);
		check_flag("rsp_valid", rsp_valid, 1'b0);
		check_flag("mem_arvalid", mem_arvalid, 1'b0);
		check_flag("mem_rready", mem_rready, 1'b0);
		for (int i = 0; i < N_FETCH; i++) begin
			if ($urandom_range(0, 19) == 0) begin
				flush_cache();
			end
			// Three tags over two sets force conflicts in a two-way cache
			if (have_prev && $urandom_range(0, 2) == 0) begin
				line = prev_line;
			end else begin
				line = 32'h0040_0000 + ($urandom_range(0, 2) << 11)
					+ ($urandom_range(0, 1) << 5);
			end
			fetch_word(line | ($urandom_range(0, 7) << 2));
			if (timed_out) begin
				break;
			end
			prev_line = line;
			have_prev = 1'b1;
			repeat ($urandom_range(0, 2)) @(negedge CLK);
		end
		$display("errors: %0d value, %0d other", err_value, err_other);
		if (err_value + err_other == 0) begin
			$display("PASS: all tests");
		end else begin
			$display("FAIL: see errors above");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== sources.f ====
hw/icache_pkg.sv
hw/icache_way_if.sv
hw/icache_way.sv
hw/victim_select.sv
hw/icache_ctrl.sv
hw/icache_top.sv
tests/icache_tb.sv
